// File: include/uartRx_consts.svh
/*
  Compile-time constants for the UART receiver. The baud rate is fixed here.
  RX_TICK_DIVISOR must be 2 or more. Frame width is fixed at 8 data bits.
*/
`ifndef UART_RX_CONSTS_SVH
`define UART_RX_CONSTS_SVH

// Ticks per bit time, mid-bit sample lands at half of this
`define RX_OVERSAMPLE 16
// Clocks per oversampling tick, 64 clocks per bit with the value above
`define RX_TICK_DIVISOR 4
`define RX_DATA_BITS 8

// Parity mode encodings, anything else means no parity
`define RX_PARITY_ODD 2'b01
`define RX_PARITY_EVEN 2'b10

// Bit positions inside the error flag vector
`define RX_ERR_PARITY 0
`define RX_ERR_START 1
`define RX_ERR_STOP 2

`endif

// File: list.f
+incdir+include
logic/uartRxPkg.sv
logic/rxFrameIf.sv
logic/rxBaudGen.sv
logic/rxDeserializer.sv
logic/errorCheck.sv
logic/uartRx.sv
tb/uartRx_chk.sv
tb/uartRxTb.sv

// File: logic/errorCheck.sv
/*
  Combinational frame checker. Flags are meaningful while frameDone is high.
  With no parity the expected bit is 1, the level the deserializer holds.
*/
`include "uartRx_consts.svh"

module errorCheck (
  input  uartRxPkg::parityMode_t parityMode,
  rxFrameIf.sink                 frame,
  output uartRxPkg::errorFlag_t  errorFlag
);

  logic dataParity;
  logic expectedParity;

  // Odd count of ones in the byte gives 1
  assign dataParity = ^frame.rawData;

  // Parity bit the transmitter should have sent
  always_comb begin
    case (parityMode)
      // Total ones must be odd
      `RX_PARITY_ODD:  expectedParity = ~dataParity;
      // Total ones must be even
      `RX_PARITY_EVEN: expectedParity = dataParity;
      // No parity bit, compare against the idle level
      default:         expectedParity = 1'b1;
    endcase
  end

  // Received parity differs from expectation
  assign errorFlag[`RX_ERR_PARITY] = (frame.parityBit != expectedParity);
  // Start bit must sample low at mid-bit
  assign errorFlag[`RX_ERR_START]  = frame.startBit;
  // Stop bit must sample high
  assign errorFlag[`RX_ERR_STOP]   = ~frame.stopBit;

endmodule

// File: logic/rxBaudGen.sv
/*
  Free-running 16x oversampling tick. One-clock strobe every RX_TICK_DIVISOR
  clocks, first one on the fourth clock after reset. No phase alignment to the line.
*/
`include "uartRx_consts.svh"

module rxBaudGen (
  input  logic clock,
  input  logic reset,
  output logic tick
);

  localparam int CountWidth = $clog2(`RX_TICK_DIVISOR);

  logic [CountWidth-1:0] count;
  logic                  wrap;

  // Last count value before rolling over
  assign wrap = (count == CountWidth'(`RX_TICK_DIVISOR - 1));

  always_ff @(posedge clock) begin
    if (reset) begin
      count <= '0;
    end else if (wrap) begin
      count <= '0;
    end else begin
      count <= count + 1'b1;
    end
  end

  // Tick only on the wrap cycle
  assign tick = wrap;

endmodule

// File: logic/rxDeserializer.sv
/*
  Turns the serial line into frame fields. Line goes through a two-flop
  synchronizer, start is a falling edge seen while idle. A failed start sample
  does not abort the frame. No parity bit is expected for modes 00 and 11.
*/
`include "uartRx_consts.svh"

module rxDeserializer (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   tick,
  input  logic                   rxLine,
  input  uartRxPkg::parityMode_t parityMode,
  rxFrameIf.source               frame
);
  import uartRxPkg::*;

  // Tick count at the start bit middle and at a full bit
  localparam logic [3:0] HalfBit = 4'(`RX_OVERSAMPLE / 2 - 1);
  localparam logic [3:0] FullBit = 4'(`RX_OVERSAMPLE - 1);
  localparam logic [2:0] LastBit = 3'(`RX_DATA_BITS - 1);

  logic       lineMeta;
  logic       lineSync;
  logic       lineLast;
  logic       lineFall;
  logic       parityOn;
  logic       bitSample;
  rxState_t   state;
  logic [3:0] tickCount;
  logic [2:0] bitCount;
  logic       stopWait;

  // Two-flop synchronizer plus one more stage for edge detection
  // Idle line is high so all stages reset to 1
  always_ff @(posedge clock) begin
    if (reset) begin
      lineMeta <= 1'b1;
      lineSync <= 1'b1;
      lineLast <= 1'b1;
    end else begin
      lineMeta <= rxLine;
      lineSync <= lineMeta;
      lineLast <= lineSync;
    end
  end

  assign lineFall  = lineLast & ~lineSync;
  assign parityOn  = (parityMode == `RX_PARITY_ODD) || (parityMode == `RX_PARITY_EVEN);
  // Middle of a data, parity or stop bit
  assign bitSample = tick && (tickCount == FullBit);

  always_ff @(posedge clock) begin
    if (reset) begin
      state           <= rxIdle;
      tickCount       <= '0;
      bitCount        <= '0;
      stopWait        <= 1'b0;
      frame.frameDone <= 1'b0;
      frame.rawData   <= '0;
      frame.startBit  <= 1'b0;
      frame.stopBit   <= 1'b1;
      // Matches the expected parity of a zero byte so flags stay clear
      frame.parityBit <= (parityMode != `RX_PARITY_EVEN);
    end else begin
      // Strobe by default low
      frame.frameDone <= 1'b0;
      case (state)
        rxIdle: begin
          if (lineFall) begin
            state           <= rxStart;
            tickCount       <= '0;
            bitCount        <= '0;
            // Held at idle level when no parity bit is sent
            frame.parityBit <= 1'b1;
          end
        end
        rxStart: begin
          if (tick) begin
            if (tickCount == HalfBit) begin
              // Kept even if high, the checker reports it
              frame.startBit <= lineSync;
              tickCount      <= '0;
              state          <= rxData;
            end else begin
              tickCount <= tickCount + 1'b1;
            end
          end
        end
        rxData: begin
          if (tick) begin
            tickCount <= tickCount + 1'b1;
          end
          if (bitSample) begin
            // LSB first, new bit enters at the top
            frame.rawData <= {lineSync, frame.rawData[`RX_DATA_BITS-1:1]};
            bitCount      <= bitCount + 1'b1;
            if (bitCount == LastBit) begin
              state <= parityOn ? rxParity : rxStop;
            end
          end
        end
        rxParity: begin
          if (tick) begin
            tickCount <= tickCount + 1'b1;
          end
          if (bitSample) begin
            frame.parityBit <= lineSync;
            state           <= rxStop;
          end
        end
        rxStop: begin
          if (stopWait) begin
            // Low stop bit, hold off until the line is back high
            if (lineSync) begin
              stopWait <= 1'b0;
              state    <= rxIdle;
            end
          end else begin
            if (tick) begin
              tickCount <= tickCount + 1'b1;
            end
            if (bitSample) begin
              frame.stopBit   <= lineSync;
              frame.frameDone <= 1'b1;
              if (lineSync) begin
                state <= rxIdle;
              end else begin
                stopWait <= 1'b1;
              end
            end
          end
        end
        default: state <= rxIdle;
      endcase
    end
  end

endmodule

// File: logic/rxFrameIf.sv
/*
  Fields of one finished frame. Values hold from frameDone until the next
  start edge is detected, frameDone is a one-cycle strobe.
*/
interface rxFrameIf;
  import uartRxPkg::*;

  // Assembled data byte, LSB received first
  rxData_t rawData;
  // Sampled levels of the framing bits
  logic parityBit;
  logic startBit;
  logic stopBit;
  // High for one clock after the stop sample
  logic frameDone;

  // Deserializer side
  modport source (
    output rawData, parityBit, startBit, stopBit, frameDone
  );

  // Checker side
  modport sink (
    input rawData, parityBit, startBit, stopBit, frameDone
  );

endinterface

// File: logic/uartRx.sv
/*
  UART receiver top level, 8N1 with optional odd or even parity.
  rxValid is a one-clock strobe with no back-pressure, take the byte then.
  rxData and errorFlag hold until the next frame starts.
*/
module uartRx (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   rxLine,
  input  uartRxPkg::parityMode_t parityMode,
  output uartRxPkg::rxData_t     rxData,
  output uartRxPkg::errorFlag_t  errorFlag,
  output logic                   rxValid
);

  // 16x oversampling strobe
  logic tick;

  // Fields of the last received frame
  rxFrameIf frameIf ();

  rxBaudGen baudGen0 (
    .clock (clock),
    .reset (reset),
    .tick  (tick)
  );

  // Serial line to frame fields
  rxDeserializer deser0 (
    .clock      (clock),
    .reset      (reset),
    .tick       (tick),
    .rxLine     (rxLine),
    .parityMode (parityMode),
    .frame      (frameIf.source)
  );

  // Parity, start and stop flags
  errorCheck check0 (
    .parityMode (parityMode),
    .frame      (frameIf.sink),
    .errorFlag  (errorFlag)
  );

  // Byte and strobe come straight from the frame fields
  assign rxData  = frameIf.rawData;
  assign rxValid = frameIf.frameDone;

endmodule

// File: logic/uartRxPkg.sv
/*
  Shared types for the UART receive path.
  Data width follows RX_DATA_BITS from the constants header.
*/
`include "uartRx_consts.svh"

package uartRxPkg;

  // One received byte
  typedef logic [`RX_DATA_BITS-1:0] rxData_t;

  // 01 odd, 10 even, 00 or 11 no parity
  typedef logic [1:0] parityMode_t;

  // Bit 0 parity, bit 1 start, bit 2 stop
  typedef logic [2:0] errorFlag_t;

  // Deserializer FSM states
  typedef enum logic [2:0] {
    rxIdle,
    rxStart,
    rxData,
    rxParity,
    rxStop
  } rxState_t;

endpackage

// File: tb/uartRxTb.sv
/*
  Testbench for uartRx. Frames come from tb/uartRx_vectors.txt, path relative
  to the project root. Stimulus changes on falling edges, 64 clocks per bit.
*/
`include "uartRx_consts.svh"

module uartRxTb;
  timeunit 1ns;
  timeprecision 1ps;
  import uartRxPkg::*;

  localparam int BitClocks   = `RX_OVERSAMPLE * `RX_TICK_DIVISOR;
  localparam int ResetCycles = 16;

  // One line of the vectors file
  typedef struct packed {
    parityMode_t mode;
    rxData_t     data;
    logic        parityFault;
    logic        startFault;
    logic        stopFault;
  } frameVector_t;

  logic         clock = 1'b0;
  logic         reset;
  logic         rxLine;
  parityMode_t  parityMode;
  rxData_t      rxData;
  errorFlag_t   errorFlag;
  logic         rxValid;
  frameVector_t vectors[$];
  logic [31:0]  rngState = 32'h8581_b35a;
  int           pulseCount = 0;
  rxData_t      seenData;
  errorFlag_t   seenFlags;
  int           cycleCount = 0;
  int           timeoutLimit = 0;

  uartRx dut0 (
    .clock      (clock),
    .reset      (reset),
    .rxLine     (rxLine),
    .parityMode (parityMode),
    .rxData     (rxData),
    .errorFlag  (errorFlag),
    .rxValid    (rxValid)
  );

  // 8 ns clock
  always #4 clock = ~clock;

  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("CHECKS FAILED");
    $fatal(1, "run aborted");
  endtask

  task automatic compareValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
    if (actual !== expected) begin
      $display("FAILED at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
      $display("CHECKS FAILED");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // Capture each strobe, values seen are those of the cycle before the edge
  always @(posedge clock) begin
    if (rxValid === 1'b1) begin
      pulseCount <= pulseCount + 1;
      seenData   <= rxData;
      seenFlags  <= errorFlag;
    end
  end

  // Run limit, set once the vectors are loaded
  always @(posedge clock) begin
    cycleCount <= cycleCount + 1;
    if (timeoutLimit > 0 && cycleCount >= timeoutLimit) begin
      abortRun($sformatf("Timeout: run still busy after %0d clock cycles", cycleCount));
    end
  end

  function automatic logic [31:0] xorshiftStep(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic loadVectors();
    int           fd;
    string        line;
    int           col[5];
    frameVector_t v;
    fd = $fopen("tb/uartRx_vectors.txt", "r");
    if (fd == 0) begin
      abortRun("Could not open tb/uartRx_vectors.txt");
    end else begin
      while ($fgets(line, fd) > 0) begin
        // Comment and blank lines
        if (line.len() < 2 || line.substr(0, 1) == "//") begin
          continue;
        end
        if ($sscanf(line, "%h %h %h %h %h", col[0], col[1], col[2], col[3], col[4]) != 5) begin
          abortRun("Malformed line in the vectors file");
        end else begin
          v = {col[0][1:0], col[1][7:0], col[2][0], col[3][0], col[4][0]};
          vectors.push_back(v);
        end
      end
      $fclose(fd);
    end
  endtask

  // Call on a falling edge, returns on a falling edge
  task automatic holdLine(input logic level, input int clocks);
    rxLine = level;
    repeat (clocks) @(negedge clock);
  endtask

  task automatic sendFrame(input frameVector_t v);
    logic parityBit;
    // Odd mode makes the total count of ones odd
    parityBit  = (v.mode == `RX_PARITY_ODD) ? ~(^v.data) : ^v.data;
    parityMode = v.mode;
    if (v.startFault) begin
      // Edge still seen, mid-bit sample reads high
      holdLine(1'b0, 16);
      holdLine(1'b1, BitClocks - 16);
    end else begin
      holdLine(1'b0, BitClocks);
    end
    // LSB first
    for (int i = 0; i < `RX_DATA_BITS; i++) begin
      holdLine(v.data[i], BitClocks);
    end
    if (v.mode == `RX_PARITY_ODD || v.mode == `RX_PARITY_EVEN) begin
      holdLine(parityBit ^ v.parityFault, BitClocks);
    end
    // Low stop bit, then a full idle bit time
    if (v.stopFault) begin
      holdLine(1'b0, BitClocks);
    end
    holdLine(1'b1, BitClocks);
  endtask

  initial begin
    frameVector_t v;
    logic         parityOn;
    errorFlag_t   expectedFlags;
    reset      = 1'b1;
    rxLine     = 1'b1;
    parityMode = '0;
    loadVectors();
    if (vectors.size() == 0) begin
      abortRun("The vectors file holds no frames");
    end
    // Longest frame is 12 bit times plus the largest idle gap
    timeoutLimit = vectors.size() * (12 * BitClocks + 32) + 1024;
    repeat (ResetCycles) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    compareValue("rxValid after reset", rxValid, 1'b0);
    compareValue("errorFlag after reset", errorFlag, 3'b000);
    compareValue("rxData after reset", rxData, 8'h00);
    compareValue("rxValid pulses in reset", pulseCount, 0);
    for (int n = 0; n < vectors.size(); n++) begin
      v = vectors[n];
      sendFrame(v);
      // Strobe normally arrives during the stop bit
      while (pulseCount < n + 1) begin
        @(negedge clock);
      end
      compareValue("rxValid pulse count", pulseCount, n + 1);
      compareValue("rxData", seenData, v.data);
      // No parity bit goes out in modes 00 and 11
      parityOn      = (v.mode == `RX_PARITY_ODD) || (v.mode == `RX_PARITY_EVEN);
      expectedFlags = {v.stopFault, v.startFault, v.parityFault & parityOn};
      compareValue("errorFlag", seenFlags, expectedFlags);
      rngState = xorshiftStep(rngState);
      holdLine(1'b1, int'(rngState[4:0]));
    end
    // Quiet line, no stray strobes
    holdLine(1'b1, 2 * BitClocks);
    compareValue("total rxValid pulses", pulseCount, vectors.size());
    if (dut0.chk0.assertFails == 0) begin
      $display("ALL CHECKS PASSED");
      $finish;
    end else begin
      $display("Bound assertions failed %0d times", dut0.chk0.assertFails);
      $display("CHECKS FAILED");
      $fatal(1, "assertion failures");
    end
  end

endmodule

// File: tb/uartRx_chk.sv
/*
  Concurrent assertions bound into every uartRx instance.
  assertFails counts failed assertions so the testbench can see them.
*/
module uartRxChk (
  input logic                  clock,
  input logic                  reset,
  input logic                  rxValid,
  input uartRxPkg::errorFlag_t errorFlag
);
  timeunit 1ns;
  timeprecision 1ps;

  int assertFails = 0;

  // Strobe is exactly one clock wide
  validPulse: assert property (@(posedge clock) disable iff (reset) rxValid |=> !rxValid)
    else begin
      assertFails++;
      $error("rxValid stayed high for two cycles");
    end

  // Outputs cleared once reset has taken effect
  resetQuiet: assert property (@(posedge clock)
    (reset && $past(reset)) |-> (!rxValid && errorFlag == '0))
    else begin
      assertFails++;
      $error("rxValid or errorFlag not zero during reset");
    end

  // Flags must be driven when the byte is offered
  flagsKnown: assert property (@(posedge clock) rxValid |-> !$isunknown(errorFlag))
    else begin
      assertFails++;
      $error("errorFlag unknown while rxValid is high");
    end

endmodule

bind uartRx uartRxChk chk0 (
  .clock     (clock),
  .reset     (reset),
  .rxValid   (rxValid),
  .errorFlag (errorFlag)
);

// File: tb/uartRx_vectors.txt
// One frame per line in hex
// parity mode, data byte, then parity, start and stop fault bits
1 a5 0 0 0
2 3c 0 0 0
0 81 0 0 0
3 ff 0 0 0
1 00 1 0 0
2 7e 1 0 0
0 55 1 0 0
3 c3 1 0 0
1 96 0 1 0
0 0f 0 1 0
2 e1 0 0 1
2 e1 0 0 0
0 f0 0 0 1
0 18 0 0 0
